// ==== sim.f ====
+incdir+source
source/hss_phy_pkg.sv
source/hss_link_pkg.sv
source/hss_rx_control.sv
source/hss_tx_control.sv
source/hss_link_top.sv
dv/hss_link_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the link testbench with Verilator and run it
# the run passes only if the pass line shows up in the output
verilator --binary --top-module hss_link_tb -f sim.f -o hss_link_sim \
	&& ./obj_dir/hss_link_sim | tee /dev/stderr | grep "all tests passed" > /dev/null \
	&& echo "simulation PASS" \
	|| { echo "simulation FAIL"; exit 1; }

// ==== dv/hss_link_tb.sv ====
// link control testbench
// loops the lane back through a byte rotation and a one-word delay, then
// runs directed tests for handshake, data, sentinel, version and resync

`timescale 1ns/1ps
`include "hss_link_defs.svh"

module hss_link_tb;

	localparam int CLK_PERIOD = 10;
	localparam int NUM_TESTS  = 6;
	localparam int LINK_SPAN  = `HSS_NUM_HANDSHAKES + `HSS_CLKC_PERIOD;
	// bound for a handshake to come up
	localparam int HS_WAIT    = 4 * LINK_SPAN;

	localparam hss_link_pkg::link_status_t STATUS_DONE = '{
		handshake_complete: 1'b1,
		handshake_phase:    1'b1,
		version_mismatch:   1'b0
	};

	// comma, handshake K, phase 0 and version on the lane after reset
	localparam hss_phy_pkg::lane_tx_t LANE_HS_PHASE0 = '{
		data:    {`HSS_KCH_COMMA, `HSS_KCH_HANDSHAKE, 8'h00, `HSS_PROTOCOL_VERSION},
		charisk: `HSS_HANDSHAKE_KBITS
	};

	logic                       CLK_IN = 1'b0;
	logic                       RESET_IN;
	hss_phy_pkg::lane_rx_t      lane_rx;
	hss_phy_pkg::lane_tx_t      lane_tx;
	hss_link_pkg::link_word_t   tx_word;
	logic                       tx_vld;
	logic                       tx_rdy;
	hss_link_pkg::link_word_t   rx_word;
	logic                       rx_vld;
	hss_link_pkg::link_status_t status;
	logic [15:0]                idle_sentinel;
	logic [15:0]                remote_sentinel;

	// lane model controls
	int                         rotation;
	logic                       corrupt_version;
	logic [1:0]                 los_code;
	hss_phy_pkg::lane_tx_t      prev_tx;

	hss_link_pkg::link_word_t   exp_q[$];
	integer                     seed;
	int                         value_errors;
	int                         other_errors;

	always #(CLK_PERIOD / 2) CLK_IN = ~CLK_IN;

	hss_link_top u_hss_link_top
	(
		.CLK_IN            (CLK_IN),
		.RESET_IN          (RESET_IN),
		.lane_rx_i         (lane_rx),
		.lane_tx_o         (lane_tx),
		.tx_word_i         (tx_word),
		.tx_vld_i          (tx_vld),
		.tx_rdy_o          (tx_rdy),
		.rx_word_o         (rx_word),
		.rx_vld_o          (rx_vld),
		.status_o          (status),
		.idle_sentinel_i   (idle_sentinel),
		.remote_sentinel_o (remote_sentinel)
	);

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_word(input string name, input hss_link_pkg::link_word_t got,
	                          input hss_link_pkg::link_word_t exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_status(input string name, input hss_link_pkg::link_status_t got,
	                            input hss_link_pkg::link_status_t exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_sentinel(input string name, input logic [15:0] got,
	                              input logic [15:0] exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_lane(input string name, input hss_phy_pkg::lane_tx_t got,
	                          input hss_phy_pkg::lane_tx_t exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_state(input string name, input hss_link_pkg::los_state_e got,
	                           input hss_link_pkg::los_state_e exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////
	// lane model and cycle stepping
	////////////////////////////////////////////////////////////

	// lane bytes go out low byte first, so a rotation delays the stream by rot bytes
	function automatic hss_phy_pkg::lane_rx_t loop_word(input hss_phy_pkg::lane_tx_t cur,
	                                                    input hss_phy_pkg::lane_tx_t prev,
	                                                    input int rot, input logic [1:0] los);
		logic [63:0]           bytes;
		logic [7:0]            kbits;
		hss_phy_pkg::lane_rx_t w;
		bytes = {cur.data, prev.data} >> (32 - 8 * rot);
		kbits = {cur.charisk, prev.charisk} >> (4 - rot);
		w.data    = bytes[31:0];
		w.charisk = kbits[3:0];
		// transceiver flags a comma on any K byte that matches
		for (int i = 0; i < 4; i++)
			w.chariscomma[i] = w.charisk[i] && (w.data[8*i +: 8] == `HSS_KCH_COMMA);
		w.lossofsync = los;
		return w;
	endfunction

	// each falling edge checks the receive stream and then moves the lane on
	task automatic advance_cycle();
		hss_phy_pkg::lane_tx_t sent;
		@(negedge CLK_IN);
		if (rx_vld)
		begin
			if (exp_q.size() == 0)
			begin
				other_errors++;
				$display("unexpected word %h on rx_word_o", rx_word);
			end
			else
				check_word("rx_word_o", rx_word, exp_q.pop_front());
		end
		sent = lane_tx;
		// bad version byte on handshake words only
		if (corrupt_version && sent.charisk == 4'b1100 && sent.data[23:16] == `HSS_KCH_HANDSHAKE)
			sent.data[7:0] = ~`HSS_PROTOCOL_VERSION;
		lane_rx = loop_word(sent, prev_tx, rotation, los_code);
		prev_tx = sent;
	endtask

	task automatic reset_link(input int rot);
		RESET_IN = 1'b1;
		rotation = rot;
		advance_cycle();
		advance_cycle();
		RESET_IN = 1'b0;
	endtask

	task automatic wait_complete(input string what);
		int n;
		n = 0;
		while (!status.handshake_complete && n < HS_WAIT)
		begin
			advance_cycle();
			n++;
		end
		if (!status.handshake_complete)
		begin
			other_errors++;
			$display("handshake did not complete within %0d cycles (%s)", HS_WAIT, what);
		end
	endtask

	// offer random words with gaps, queue each one the transmitter takes
	task automatic send_data(input int count);
		int accepted;
		int cycles;
		accepted = 0;
		cycles   = 0;
		while (accepted < count && cycles < 8 * count)
		begin
			tx_vld       = (($random(seed) & 3) != 0);
			tx_word.data = $random(seed);
			tx_word.charisk = 4'b0000;
			// ready is stable until the next rising edge
			if (tx_vld && tx_rdy)
			begin
				exp_q.push_back(tx_word);
				accepted++;
			end
			advance_cycle();
			cycles++;
		end
		tx_vld = 1'b0;
		if (accepted < count)
		begin
			other_errors++;
			$display("only %0d of %0d words were taken by the transmitter", accepted, count);
		end
		cycles = 0;
		while (exp_q.size() != 0 && cycles < `HSS_CLKC_PERIOD)
		begin
			advance_cycle();
			cycles++;
		end
		if (exp_q.size() != 0)
		begin
			other_errors++;
			$display("%0d sent words never arrived on rx_word_o", exp_q.size());
			exp_q.delete();
		end
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	task automatic test_reset_values();
		check_flag("rx_vld_o", rx_vld, 1'b0);
		check_status("status_o", status, '0);
		check_sentinel("remote_sentinel_o", remote_sentinel, 16'hFFFF);
		check_flag("tx_rdy_o", tx_rdy, 1'b0);
		check_lane("lane_tx_o", lane_tx, LANE_HS_PHASE0);
	endtask

	task automatic test_handshake_rotations();
		for (int rot = 0; rot < 4; rot++)
		begin
			reset_link(rot);
			wait_complete($sformatf("rotation %0d", rot));
			check_status("status_o", status, STATUS_DONE);
			// only idle and clkc words follow so the receive stream stays quiet
			repeat (LINK_SPAN) advance_cycle();
		end
	endtask

	task automatic test_data_stream();
		send_data(64);
	endtask

	task automatic test_sentinel();
		int n;
		idle_sentinel = 16'hC3E1;
		n = 0;
		while (remote_sentinel !== 16'hC3E1 && n < `HSS_CLKC_PERIOD)
		begin
			advance_cycle();
			n++;
		end
		check_sentinel("remote_sentinel_o", remote_sentinel, 16'hC3E1);
	endtask

	task automatic test_version_mismatch();
		logic seen_mismatch;
		logic seen_complete;
		seen_mismatch   = 1'b0;
		seen_complete   = 1'b0;
		corrupt_version = 1'b1;
		reset_link(rotation);
		repeat (2 * LINK_SPAN)
		begin
			advance_cycle();
			seen_mismatch |= status.version_mismatch;
			seen_complete |= status.handshake_complete;
		end
		check_flag("version_mismatch", seen_mismatch, 1'b1);
		check_flag("handshake_complete", seen_complete, 1'b0);
		corrupt_version = 1'b0;
		wait_complete("after version fault removed");
		check_status("status_o", status, STATUS_DONE);
	endtask

	task automatic test_loss_of_sync();
		int n;
		hss_link_pkg::los_state_e st;
		los_code = 2'b10;
		n = 0;
		while (status.handshake_complete && n < `HSS_CLKC_PERIOD)
		begin
			advance_cycle();
			n++;
		end
		check_status("status_o", status, '0);
		repeat (8) advance_cycle();
		los_code = 2'b01;
		// the dwell has only just started after two rising edges
		repeat (3) advance_cycle();
		st = u_hss_link_top.u_rx_control.los_state;
		check_state("los_state", st, hss_link_pkg::LOS_RESYNC);
		repeat (`HSS_NUM_CLKC_FOR_SYNC + 1) advance_cycle();
		st = u_hss_link_top.u_rx_control.los_state;
		$display("resync dwell over, rx state %s", st.name());
		check_state("los_state", st, hss_link_pkg::LOS_SYNCED);
		los_code = 2'b00;
		wait_complete("after loss of sync");
		check_status("status_o", status, STATUS_DONE);
		send_data(32);
	endtask

	////////////////////////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////////////////////////

	initial
	begin
		seed            = 32'he0e4;
		value_errors    = 0;
		other_errors    = 0;
		RESET_IN        = 1'b1;
		lane_rx         = '0;
		prev_tx         = '0;
		tx_word         = '0;
		tx_vld          = 1'b0;
		idle_sentinel   = 16'h5A5A;
		corrupt_version = 1'b0;
		los_code        = 2'b00;
		rotation        = 0;
		reset_link(0);
		test_reset_values();
		test_handshake_rotations();
		test_data_stream();
		test_sentinel();
		test_version_mismatch();
		test_loss_of_sync();
		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	// run length scales with the number of tests and the link timing
	initial
	begin
		#(NUM_TESTS * LINK_SPAN * 20 * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		$display("tests failed");
		$finish;
	end

endmodule

// ==== source/hss_link_top.sv ====
// link control top level
// receive and transmit controls sharing one status bundle, so a single
// instance can run against itself over an external loopback

`timescale 1ns/1ps

module hss_link_top
(
	input  logic                       CLK_IN,
	input  logic                       RESET_IN,
	// transceiver lane
	input  hss_phy_pkg::lane_rx_t      lane_rx_i,
	output hss_phy_pkg::lane_tx_t      lane_tx_o,
	// internal transmit stream
	input  hss_link_pkg::link_word_t   tx_word_i,
	input  logic                       tx_vld_i,
	output logic                       tx_rdy_o,
	// internal receive stream
	output hss_link_pkg::link_word_t   rx_word_o,
	output logic                       rx_vld_o,
	// status and sentinels
	output hss_link_pkg::link_status_t status_o,
	input  logic [15:0]                idle_sentinel_i,
	output logic [15:0]                remote_sentinel_o
);

	hss_rx_control u_rx_control
	(
		.CLK_IN            (CLK_IN),
		.RESET_IN          (RESET_IN),
		.lane_rx_i         (lane_rx_i),
		.status_o          (status_o),
		.remote_sentinel_o (remote_sentinel_o),
		.rx_word_o         (rx_word_o),
		.rx_vld_o          (rx_vld_o)
	);

	// transmit side reads the status straight from the receiver
	hss_tx_control u_tx_control
	(
		.CLK_IN          (CLK_IN),
		.RESET_IN        (RESET_IN),
		.status_i        (status_o),
		.idle_sentinel_i (idle_sentinel_i),
		.tx_word_i       (tx_word_i),
		.tx_vld_i        (tx_vld_i),
		.tx_rdy_o        (tx_rdy_o),
		.lane_tx_o       (lane_tx_o)
	);

endmodule

// ==== source/hss_tx_control.sv ====
// transmit link control
// picks handshake, clock-correction, idle or data for each lane word
// and registers it onto the lane

`timescale 1ns/1ps
`include "hss_link_defs.svh"

module hss_tx_control
(
	input  logic                       CLK_IN,
	input  logic                       RESET_IN,
	input  hss_link_pkg::link_status_t status_i,
	input  logic [`HSS_IDLE_BITS-1:0]  idle_sentinel_i,
	input  hss_link_pkg::link_word_t   tx_word_i,
	input  logic                       tx_vld_i,
	output logic                       tx_rdy_o,
	output hss_phy_pkg::lane_tx_t      lane_tx_o
);

	localparam int CLKC_CNT_BITS = $clog2(`HSS_CLKC_PERIOD);

	// phase 0 handshake, also the lane word straight after reset
	localparam hss_phy_pkg::lane_tx_t HS_RESET_WORD = '{
		data:    {`HSS_KCH_COMMA, `HSS_KCH_HANDSHAKE, 8'h00, `HSS_PROTOCOL_VERSION},
		charisk: `HSS_HANDSHAKE_KBITS
	};

	logic [CLKC_CNT_BITS-1:0] clkc_cnt;
	logic                     clkc_due;
	hss_link_pkg::tx_slot_e   slot;
	hss_phy_pkg::lane_tx_t    next_word;

	////////////////////////////////////////////////////////////
	// clock-correction interval
	////////////////////////////////////////////////////////////

	// free running, independent of link state
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			clkc_cnt <= '0;
		else if (clkc_due)
			clkc_cnt <= '0;
		else
			clkc_cnt <= clkc_cnt + 1'b1;
	end

	assign clkc_due = (clkc_cnt == CLKC_CNT_BITS'(`HSS_CLKC_PERIOD - 1));

	// a data slot is free only after completion and outside clkc slots
	assign tx_rdy_o = status_i.handshake_complete && !clkc_due;

	////////////////////////////////////////////////////////////
	// slot choice and lane word
	////////////////////////////////////////////////////////////

	always_comb
	begin
		if (clkc_due)
			slot = hss_link_pkg::SLOT_CLKC;
		else if (!status_i.handshake_complete)
			slot = hss_link_pkg::SLOT_HANDSHAKE;
		else if (tx_vld_i)
			slot = hss_link_pkg::SLOT_DATA;
		else
			slot = hss_link_pkg::SLOT_IDLE;
	end

	always_comb
	begin
		case (slot)
			hss_link_pkg::SLOT_CLKC:
				next_word = '{data: {4{`HSS_KCH_CLKC}}, charisk: `HSS_CLKC_KBITS};
			// phase byte carries the phase the receiver wants us to send
			hss_link_pkg::SLOT_HANDSHAKE:
				next_word = '{data: {`HSS_KCH_COMMA, `HSS_KCH_HANDSHAKE,
				                     7'd0, status_i.handshake_phase, `HSS_PROTOCOL_VERSION},
				              charisk: `HSS_HANDSHAKE_KBITS};
			hss_link_pkg::SLOT_DATA:
				next_word = '{data: tx_word_i.data, charisk: tx_word_i.charisk};
			// idle frame carries our sentinel in the low half
			default:
				next_word = '{data: {`HSS_KCH_IDLE, idle_sentinel_i}, charisk: `HSS_IDLE_KBITS};
		endcase
	end

	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			lane_tx_o <= HS_RESET_WORD;
		else
			lane_tx_o <= next_word;
	end

endmodule

// ==== source/hss_rx_control.sv ====
// receive link control
// follows lane sync, regains word alignment from commas, tracks the
// version handshake, latches the remote sentinel and passes only data on

`timescale 1ns/1ps
`include "hss_link_defs.svh"

module hss_rx_control
(
	input  logic                       CLK_IN,
	input  logic                       RESET_IN,
	input  hss_phy_pkg::lane_rx_t      lane_rx_i,
	output hss_link_pkg::link_status_t status_o,
	output logic [`HSS_IDLE_BITS-1:0]  remote_sentinel_o,
	output hss_link_pkg::link_word_t   rx_word_o,
	output logic                       rx_vld_o
);

	hss_link_pkg::los_state_e los_state;
	logic [2:0]  los_cnt;
	logic        byte_aligned;
	logic [31:8] last_data;
	logic [3:1]  last_charisk;
	logic [63:8] unaligned_data;
	logic [7:1]  unaligned_charisk;
	hss_link_pkg::link_word_t aligned;
	logic [3:0]  alignment;
	logic        word_aligned;
	logic        is_clkc;
	logic        is_handshake;
	logic        is_idle;
	logic        hs_phase_in;
	logic        last_phase_in;
	logic        version_ok;
	logic        restart;
	logic [`HSS_NUM_HANDSHAKES_BITS-1:0] hs_count;
	logic        hs_phase;
	logic        hs_complete;
	logic        version_mismatch;
	logic        keep_word;

	////////////////////////////////////////////////////////////
	// resync state machine
	////////////////////////////////////////////////////////////

	// dwell counter only runs while resyncing on code 01
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			los_cnt <= '0;
		else if (los_state == hss_link_pkg::LOS_RESYNC && lane_rx_i.lossofsync == 2'b01)
			los_cnt <= los_cnt + 3'd1;
		else
			los_cnt <= '0;
	end

	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			los_state <= hss_link_pkg::LOS_LOST;
		else
		begin
			case (lane_rx_i.lossofsync)
				// lane reports sync, take it at once
				2'b00: los_state <= hss_link_pkg::LOS_SYNCED;
				2'b01:
				begin
					if (los_state == hss_link_pkg::LOS_LOST)
						los_state <= hss_link_pkg::LOS_RESYNC;
					else if (los_state == hss_link_pkg::LOS_RESYNC &&
					         los_cnt >= `HSS_NUM_CLKC_FOR_SYNC)
						los_state <= hss_link_pkg::LOS_SYNCED;
				end
				// 10 is loss of sync, 11 is not expected but treated alike
				default: los_state <= hss_link_pkg::LOS_LOST;
			endcase
		end
	end

	assign byte_aligned = (los_state == hss_link_pkg::LOS_SYNCED);

	////////////////////////////////////////////////////////////
	// word alignment
	////////////////////////////////////////////////////////////

	// upper three bytes of the previous lane word complete a split word
	always_ff @(posedge CLK_IN)
	begin
		last_data    <= lane_rx_i.data[31:8];
		last_charisk <= lane_rx_i.charisk[3:1];
	end

	assign unaligned_data    = {lane_rx_i.data, last_data};
	assign unaligned_charisk = {lane_rx_i.charisk, last_charisk};

	// one-hot offset gives the lane byte that holds the comma
	always_comb
	begin
		case (alignment)
			4'b0001: aligned = '{data: unaligned_data[39:8],  charisk: unaligned_charisk[4:1]};
			4'b0010: aligned = '{data: unaligned_data[47:16], charisk: unaligned_charisk[5:2]};
			4'b0100: aligned = '{data: unaligned_data[55:24], charisk: unaligned_charisk[6:3]};
			4'b1000: aligned = '{data: unaligned_data[63:32], charisk: unaligned_charisk[7:4]};
			default: aligned = '0;
		endcase
	end

	// commas only ever sit in the top byte of a word, so any flag fixes the offset
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			alignment <= '0;
		else if (!byte_aligned)
			alignment <= '0;
		else if (lane_rx_i.chariscomma != 4'b0000)
			alignment <= lane_rx_i.chariscomma;
	end

	assign word_aligned = byte_aligned && (alignment != 4'b0000);

	////////////////////////////////////////////////////////////
	// word classification and handshake
	////////////////////////////////////////////////////////////

	assign is_clkc = word_aligned
	              && aligned.data == {4{`HSS_KCH_CLKC}}
	              && aligned.charisk == `HSS_CLKC_KBITS;

	// comma, handshake K, phase byte, version
	assign is_handshake = word_aligned
	                   && aligned.data[31:24] == `HSS_KCH_COMMA
	                   && aligned.data[23:16] == `HSS_KCH_HANDSHAKE
	                   && aligned.charisk == `HSS_HANDSHAKE_KBITS;

	assign is_idle = word_aligned
	              && aligned.data[31:16] == `HSS_KCH_IDLE
	              && aligned.charisk == `HSS_IDLE_KBITS;

	assign hs_phase_in = aligned.data[8];
	assign version_ok  = (aligned.data[7:0] == `HSS_PROTOCOL_VERSION);

	// mismatch follows each handshake, low between them
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			version_mismatch <= 1'b0;
		else
			version_mismatch <= is_handshake && !version_ok;
	end

	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			last_phase_in <= 1'b0;
		else if (is_handshake)
			last_phase_in <= hs_phase_in;
	end

	// lost alignment, remote restarting, or an incompatible far end
	assign restart = !word_aligned
	              || (is_handshake && (hs_phase_in < last_phase_in))
	              || (is_handshake && !version_ok);

	// consecutive good handshakes; clkc words neither count nor break the run
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			hs_count <= '0;
		else if (is_handshake && !restart)
		begin
			if (hs_count < `HSS_NUM_HANDSHAKES)
				hs_count <= hs_count + 1'b1;
		end
		else if (!is_clkc)
			hs_count <= '0;
	end

	assign hs_phase = (hs_count == `HSS_NUM_HANDSHAKES);

	// done once in phase 1 and the far end says phase 1 too
	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			hs_complete <= 1'b0;
		else if (restart)
			hs_complete <= 1'b0;
		else if (hs_phase && is_handshake && hs_phase_in)
			hs_complete <= 1'b1;
	end

	assign status_o = '{handshake_complete: hs_complete,
	                    handshake_phase:    hs_phase,
	                    version_mismatch:   version_mismatch};

	////////////////////////////////////////////////////////////
	// sentinel and stream output
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			remote_sentinel_o <= '1;
		else if (is_idle)
			remote_sentinel_o <= aligned.data[`HSS_IDLE_BITS-1:0];
	end

	assign keep_word = word_aligned && hs_complete && !is_clkc && !is_handshake && !is_idle;

	always_ff @(posedge CLK_IN or posedge RESET_IN)
	begin
		if (RESET_IN)
			rx_vld_o <= 1'b0;
		else
			rx_vld_o <= keep_word;
	end

	// payload only moves with a valid word
	always_ff @(posedge CLK_IN)
	begin
		if (keep_word)
			rx_word_o <= aligned;
	end

endmodule

// ==== source/hss_link_pkg.sv ====
// link layer types
// internal stream word, link status bundle and the control enums

package hss_link_pkg;

	// internal 32-bit stream word with its K-bits
	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  charisk;
	} link_word_t;

	// link status, driven by the receive control
	typedef struct packed {
		logic handshake_complete;
		// phase this end should send next
		logic handshake_phase;
		logic version_mismatch;
	} link_status_t;

	// resync state machine, encoded like the lossofsync code
	typedef enum logic [1:0] {
		LOS_SYNCED = 2'b00,
		LOS_RESYNC = 2'b01,
		LOS_LOST   = 2'b10
	} los_state_e;

	// kind of word the transmit control puts on the lane
	typedef enum logic [1:0] {
		SLOT_HANDSHAKE = 2'b00,
		SLOT_CLKC      = 2'b01,
		SLOT_IDLE      = 2'b10,
		SLOT_DATA      = 2'b11
	} tx_slot_e;

endpackage

// ==== source/hss_phy_pkg.sv ====
// transceiver lane types
// one lane word in each direction, as seen at the transceiver boundary

package hss_phy_pkg;

	// received lane word, 42 bits
	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  charisk;
		logic [3:0]  chariscomma;
		// 00 synced, 01 resync, 10 lost
		logic [1:0]  lossofsync;
	} lane_rx_t;

	// transmitted lane word, 36 bits
	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  charisk;
	} lane_tx_t;

endpackage

// ==== source/hss_link_defs.svh ====
// link control constants
// control characters, K-bit masks, protocol version and link timing
// shared by the receive and transmit controls and the testbench

`ifndef HSS_LINK_DEFS_SVH
`define HSS_LINK_DEFS_SVH

// K-characters, one byte each
`define HSS_KCH_COMMA        8'hBC
`define HSS_KCH_HANDSHAKE    8'hF7
`define HSS_KCH_CLKC         8'h1C
// idle marker is a comma followed by the idle K-character
`define HSS_KCH_IDLE         {`HSS_KCH_COMMA, 8'h7C}

// K-bit masks for each control word
`define HSS_IDLE_KBITS       4'b1100
`define HSS_HANDSHAKE_KBITS  4'b1100
`define HSS_CLKC_KBITS       4'b1111

// sentinel carried in the low half of an idle frame
`define HSS_IDLE_BITS        16

`define HSS_PROTOCOL_VERSION 8'h01

// consecutive handshakes before phase 1, and the counter width
`define HSS_NUM_HANDSHAKES      16
`define HSS_NUM_HANDSHAKES_BITS 5

// lane words between clock-correction words
`define HSS_CLKC_PERIOD      32
// cycles spent in resync before the lane counts as synced
`define HSS_NUM_CLKC_FOR_SYNC 4

`endif
